//--- Makefile
# Verilator flow for the rv core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+12
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(FILELIST) $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	$(SIM_BIN) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+.
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_lsu.sv
rv_mem_arbiter.sv
rv_execute.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

//--- rv_bus_pkg.sv
//############################################################################
// rv bus types
// word request and response records of the valid/ready memory bus and
// the requester identity kept by the arbiter
//############################################################################
`default_nettype none
`include "rv_consts.svh"

package rv_bus_pkg;

  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic                write;
  } mem_req_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {own_none, own_fetch, own_lsu} owner_e;

endpackage

`default_nettype wire

//--- rv_consts.svh
//############################################################################
// rv core constants
// word width, register count, reset pc and bus latency limits shared by
// the packages, the RTL and the testbench
//############################################################################
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN 32
`define RV_NUM_REGS 32
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 4

// response latency range of the external bus, in cycles
`define RV_MIN_LAT 1
`define RV_MAX_LAT 4

`endif

//--- rv_core.sv
//############################################################################
// rv core top
// fetch, execute, register file and lsu sharing one word bus through
// the arbiter
//############################################################################
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  wire                   clk,
  input  wire                   rst,
  output logic                  bus_req_valid,
  output rv_bus_pkg::mem_req_t  bus_req,
  input  wire                   bus_req_ready,
  input  wire                   bus_rsp_valid,
  input  rv_bus_pkg::mem_rsp_t  bus_rsp,
  output logic                  halt
);

  rv_bus_pkg::mem_req_t fetch_req, lsu_req, mem_req;
  rv_isa_pkg::word_t    insn, pc, redirect_pc, rs1_data, rs2_data, rf_data, mem_rdata;
  rv_isa_pkg::reg_idx_t rs1, rs2, rf_rd;
  logic fetch_req_valid, fetch_req_ready, fetch_rsp_valid;
  logic lsu_req_valid, lsu_req_ready, lsu_rsp_valid;
  logic insn_valid, insn_ready, redirect_valid, rf_we;
  logic mem_valid, mem_ready, mem_done;

  rv_fetch u_fetch (
    .clk, .rst,
    .req_valid(fetch_req_valid), .req(fetch_req), .req_ready(fetch_req_ready),
    .rsp_valid(fetch_rsp_valid), .rsp(bus_rsp),
    .insn_valid, .insn, .pc, .insn_ready,
    .redirect_valid, .redirect_pc, .halt
  );

  rv_lsu u_lsu (
    .clk, .rst,
    .op_valid(mem_valid), .op(mem_req), .op_ready(mem_ready),
    .done(mem_done), .rdata(mem_rdata),
    .req_valid(lsu_req_valid), .req(lsu_req), .req_ready(lsu_req_ready),
    .rsp_valid(lsu_rsp_valid), .rsp(bus_rsp)
  );

  rv_mem_arbiter u_arb (
    .clk, .rst,
    .f_req_valid(fetch_req_valid), .f_req(fetch_req), .f_req_ready(fetch_req_ready),
    .f_rsp_valid(fetch_rsp_valid),
    .l_req_valid(lsu_req_valid), .l_req(lsu_req), .l_req_ready(lsu_req_ready),
    .l_rsp_valid(lsu_rsp_valid),
    .bus_req_valid, .bus_req, .bus_req_ready, .bus_rsp_valid
  );

  rv_execute u_exec (
    .clk, .rst,
    .insn_valid, .insn, .pc, .insn_ready, .redirect_valid, .redirect_pc,
    .rs1, .rs2, .rs1_data, .rs2_data, .rf_we, .rf_rd, .rf_data,
    .mem_valid, .mem_req, .mem_ready, .mem_done, .mem_rdata, .halt
  );

  rv_regfile u_rf (
    .clk, .rst,
    .rs1, .rs2, .rs1_data, .rs2_data,
    .we(rf_we), .rd(rf_rd), .rd_data(rf_data)
  );

endmodule

`default_nettype wire

//--- rv_core_asserts.sv
//############################################################################
// rv core assertions
// bus request stability, responses only while a request is outstanding,
// and a sticky halt with no bus traffic after it
//############################################################################
`timescale 1ns/10ps
`default_nettype none

module rv_core_asserts (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   bus_req_valid,
  input  rv_bus_pkg::mem_req_t  bus_req,
  input  wire                   bus_req_ready,
  input  wire                   bus_rsp_valid,
  input  wire                   halt,
  input  rv_bus_pkg::owner_e    owner
);

  // stalled request holds valid and contents
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req))
    else $error("bus request changed while stalled");

  a_rsp_owned: assert property (@(posedge clk) disable iff (rst)
    bus_rsp_valid |-> owner != rv_bus_pkg::own_none)
    else $error("bus response with no request outstanding");

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt)
    else $error("halt dropped without reset");

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halt |-> !bus_req_valid)
    else $error("bus request while halted");

endmodule

bind rv_core rv_core_asserts u_asserts (
  .clk, .rst, .bus_req_valid, .bus_req, .bus_req_ready, .bus_rsp_valid, .halt,
  .owner(u_arb.owner)
);

`default_nettype wire

//--- rv_execute.sv
//############################################################################
// rv execute
// decodes one instruction, runs the alu and branch compare, sequences
// loads and stores through the lsu and stops the core on ecall or an
// unsupported opcode
//############################################################################
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module rv_execute (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   insn_valid,
  input  rv_isa_pkg::word_t     insn,
  input  rv_isa_pkg::word_t     pc,
  output logic                  insn_ready,
  output logic                  redirect_valid,
  output rv_isa_pkg::word_t     redirect_pc,
  output rv_isa_pkg::reg_idx_t  rs1,
  output rv_isa_pkg::reg_idx_t  rs2,
  input  rv_isa_pkg::word_t     rs1_data,
  input  rv_isa_pkg::word_t     rs2_data,
  output logic                  rf_we,
  output rv_isa_pkg::reg_idx_t  rf_rd,
  output rv_isa_pkg::word_t     rf_data,
  output logic                  mem_valid,
  output rv_bus_pkg::mem_req_t  mem_req,
  input  wire                   mem_ready,
  input  wire                   mem_done,
  input  rv_isa_pkg::word_t     mem_rdata,
  output logic                  halt
);

  typedef enum logic [1:0] {ex_run, ex_mem_wait, ex_halted} ex_state_e;

  ex_state_e            state;
  rv_isa_pkg::decoded_t dec;
  rv_isa_pkg::word_t    imm_i, imm_s, imm_b, imm_u;
  rv_isa_pkg::word_t    op_b, alu_res, seq_pc, mem_addr, ret_pc;
  rv_isa_pkg::reg_idx_t ld_rd;
  rv_bus_pkg::mem_req_t mem_req_q;
  logic [2:0] funct3;
  logic accept, is_mem, writes_rd, taken, mem_valid_q, is_load_q, in_wait;

  function automatic rv_isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      3'b001:  return rv_isa_pkg::alu_sll;
      3'b010:  return rv_isa_pkg::alu_slt;
      3'b011:  return rv_isa_pkg::alu_sltu;
      3'b100:  return rv_isa_pkg::alu_xor;
      3'b101:  return alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
      3'b110:  return rv_isa_pkg::alu_or;
      default: return rv_isa_pkg::alu_and;
    endcase
  endfunction

  assign funct3 = insn[14:12];
  assign imm_i  = {{20{insn[31]}}, insn[31:20]};
  assign imm_s  = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b  = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u  = {insn[31:12], 12'd0};

  always_comb begin
    dec         = '0;
    dec.rs1     = insn[19:15];
    dec.rs2     = insn[24:20];
    dec.rd      = insn[11:7];
    dec.imm     = imm_i;
    dec.alu_op  = rv_isa_pkg::alu_add;
    dec.use_imm = 1'b1;
    // anything not matched below stops the core
    dec.kind    = rv_isa_pkg::kind_halt;
    case (rv_isa_pkg::opcode_e'(insn[6:0]))
      rv_isa_pkg::op_lui: begin
        dec.kind = rv_isa_pkg::kind_lui;
        dec.imm  = imm_u;
      end
      rv_isa_pkg::op_imm: begin
        dec.kind   = rv_isa_pkg::kind_alu;
        dec.alu_op = alu_sel(funct3, insn[30] && funct3 == 3'b101);
      end
      rv_isa_pkg::op_reg: begin
        // funct7 bit 0 marks the dropped M extension
        dec.kind    = insn[25] ? rv_isa_pkg::kind_halt : rv_isa_pkg::kind_alu;
        dec.alu_op  = alu_sel(funct3, insn[30]);
        dec.use_imm = 1'b0;
      end
      rv_isa_pkg::op_branch: begin
        dec.kind = funct3[2:1] == 2'b01 ? rv_isa_pkg::kind_halt : rv_isa_pkg::kind_branch;
        dec.imm  = imm_b;
      end
      rv_isa_pkg::op_load: begin
        dec.kind = funct3 == 3'b010 ? rv_isa_pkg::kind_load : rv_isa_pkg::kind_halt;
      end
      rv_isa_pkg::op_store: begin
        dec.kind = funct3 == 3'b010 ? rv_isa_pkg::kind_store : rv_isa_pkg::kind_halt;
        dec.imm  = imm_s;
      end
      default: begin
        dec.kind = rv_isa_pkg::kind_halt;
      end
    endcase
  end

  assign op_b = dec.use_imm ? dec.imm : rs2_data;

  always_comb begin
    case (dec.alu_op)
      rv_isa_pkg::alu_sub:  alu_res = rs1_data - op_b;
      rv_isa_pkg::alu_sll:  alu_res = rs1_data << op_b[4:0];
      rv_isa_pkg::alu_slt:  alu_res = {31'd0, $signed(rs1_data) < $signed(op_b)};
      rv_isa_pkg::alu_sltu: alu_res = {31'd0, rs1_data < op_b};
      rv_isa_pkg::alu_xor:  alu_res = rs1_data ^ op_b;
      rv_isa_pkg::alu_srl:  alu_res = rs1_data >> op_b[4:0];
      rv_isa_pkg::alu_sra:  alu_res = $signed(rs1_data) >>> op_b[4:0];
      rv_isa_pkg::alu_or:   alu_res = rs1_data | op_b;
      rv_isa_pkg::alu_and:  alu_res = rs1_data & op_b;
      default:              alu_res = rs1_data + op_b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  taken = rs1_data == rs2_data;
      3'b001:  taken = rs1_data != rs2_data;
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      default: taken = rs1_data >= rs2_data;
    endcase
  end

  assign seq_pc    = pc + `RV_PC_STEP;
  assign mem_addr  = (rs1_data + dec.imm) & ~32'd3;
  assign is_mem    = dec.kind == rv_isa_pkg::kind_load || dec.kind == rv_isa_pkg::kind_store;
  assign writes_rd = dec.kind == rv_isa_pkg::kind_alu || dec.kind == rv_isa_pkg::kind_lui;
  assign in_wait   = state == ex_mem_wait;

  assign insn_ready = state == ex_run;
  assign accept     = insn_valid && insn_ready;
  assign rs1        = dec.rs1;
  assign rs2        = dec.rs2;
  assign halt       = state == ex_halted;
  assign mem_valid  = mem_valid_q;
  assign mem_req    = mem_req_q;

  // alu, lui and branch retire on accept, memory ops on done
  assign redirect_valid = (accept && (writes_rd || dec.kind == rv_isa_pkg::kind_branch))
                          || (in_wait && mem_done);
  assign redirect_pc = in_wait ? ret_pc
                     : (dec.kind == rv_isa_pkg::kind_branch && taken) ? pc + dec.imm
                     : seq_pc;

  assign rf_we   = (accept && writes_rd) || (in_wait && mem_done && is_load_q);
  assign rf_rd   = in_wait ? ld_rd : dec.rd;
  assign rf_data = in_wait ? mem_rdata
                 : (dec.kind == rv_isa_pkg::kind_lui) ? dec.imm : alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ex_run;
      mem_valid_q <= 1'b0;
    end else begin
      if (mem_valid_q && mem_ready) begin
        mem_valid_q <= 1'b0;
      end
      case (state)
        ex_run: begin
          if (accept && is_mem) begin
            state       <= ex_mem_wait;
            mem_valid_q <= 1'b1;
          end else if (accept && dec.kind == rv_isa_pkg::kind_halt) begin
            state <= ex_halted;
          end
        end
        ex_mem_wait: begin
          if (mem_done) begin
            state <= ex_run;
          end
        end
        default: state <= ex_halted;
      endcase
    end
  end

  // context of the pending memory op
  always_ff @(posedge clk) begin
    if (accept && is_mem) begin
      mem_req_q <= '{addr: mem_addr, wdata: rs2_data,
                     write: dec.kind == rv_isa_pkg::kind_store};
      ld_rd     <= dec.rd;
      is_load_q <= dec.kind == rv_isa_pkg::kind_load;
      ret_pc    <= seq_pc;
    end
  end

endmodule

`default_nettype wire

//--- rv_fetch.sv
//############################################################################
// rv instruction fetch
// holds the fetch pc and a one-deep instruction buffer, prefetches the
// next sequential word and drops stale responses after a redirect
//############################################################################
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module rv_fetch (
  input  wire                   clk,
  input  wire                   rst,
  output logic                  req_valid,
  output rv_bus_pkg::mem_req_t  req,
  input  wire                   req_ready,
  input  wire                   rsp_valid,
  input  rv_bus_pkg::mem_rsp_t  rsp,
  output logic                  insn_valid,
  output rv_isa_pkg::word_t     insn,
  output rv_isa_pkg::word_t     pc,
  input  wire                   insn_ready,
  input  wire                   redirect_valid,
  input  rv_isa_pkg::word_t     redirect_pc,
  input  wire                   halt
);

  // fetch_pc is the address requested and, once buffered, the insn pc
  rv_isa_pkg::word_t fetch_pc;
  rv_isa_pkg::word_t seq_pc;
  rv_isa_pkg::word_t buf_insn;
  logic req_pending;
  logic in_flight;
  logic stale;
  logic buf_valid;
  logic take;
  logic fire;
  logic jump;

  assign seq_pc     = fetch_pc + `RV_PC_STEP;
  assign req_valid  = req_pending && !halt;
  assign req        = '{addr: fetch_pc, wdata: '0, write: 1'b0};
  assign insn_valid = buf_valid;
  assign insn       = buf_insn;
  assign pc         = fetch_pc;
  assign take       = insn_valid && insn_ready;
  assign fire       = req_valid && req_ready;
  // a redirect to the address already being fetched is no jump
  assign jump = redirect_valid && (redirect_pc != (take ? seq_pc : fetch_pc));

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc    <= `RV_RESET_PC;
      req_pending <= 1'b1;
      in_flight   <= 1'b0;
      stale       <= 1'b0;
      buf_valid   <= 1'b0;
    end else begin
      if (fire) begin
        req_pending <= 1'b0;
        in_flight   <= 1'b1;
      end
      if (rsp_valid) begin
        in_flight <= 1'b0;
        stale     <= 1'b0;
        buf_valid <= !stale;
      end
      if (take) begin
        buf_valid   <= 1'b0;
        fetch_pc    <= seq_pc;
        req_pending <= 1'b1;
      end
      if (jump) begin
        buf_valid   <= 1'b0;
        fetch_pc    <= redirect_pc;
        req_pending <= 1'b1;
        // whatever is still on its way belongs to the old path
        stale       <= (in_flight && !rsp_valid) || fire;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid && !stale) begin
      buf_insn <= rsp.rdata;
    end
  end

endmodule

`default_nettype wire

//--- rv_isa_pkg.sv
//############################################################################
// rv isa types
// word and register index vectors, opcode and alu encodings and the
// decoded instruction record used by the execute stage
//############################################################################
`default_nettype none
`include "rv_consts.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes of the kept instruction set
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    kind_alu, kind_lui, kind_branch, kind_load, kind_store, kind_halt
  } insn_kind_e;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    alu_op_e    alu_op;
    logic       use_imm;
    insn_kind_e kind;
  } decoded_t;

endpackage

`default_nettype wire

//--- rv_lsu.sv
//############################################################################
// rv load/store unit
// takes one word access from execute, holds it on the bus until it is
// accepted and pulses done together with the response data
//############################################################################
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   op_valid,
  input  rv_bus_pkg::mem_req_t  op,
  output logic                  op_ready,
  output logic                  done,
  output rv_isa_pkg::word_t     rdata,
  output logic                  req_valid,
  output rv_bus_pkg::mem_req_t  req,
  input  wire                   req_ready,
  input  wire                   rsp_valid,
  input  rv_bus_pkg::mem_rsp_t  rsp
);

  typedef enum logic {lsu_idle, lsu_wait} lsu_state_e;

  lsu_state_e           state;
  rv_bus_pkg::mem_req_t op_q;
  logic                 sent;

  assign op_ready  = state == lsu_idle;
  assign req_valid = state == lsu_wait && !sent;
  assign req       = op_q;
  assign done      = state == lsu_wait && sent && rsp_valid;
  assign rdata     = rsp.rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= lsu_idle;
      sent  <= 1'b0;
    end else begin
      case (state)
        lsu_idle: begin
          if (op_valid) begin
            state <= lsu_wait;
            sent  <= 1'b0;
          end
        end
        default: begin
          if (req_valid && req_ready) begin
            sent <= 1'b1;
          end
          if (done) begin
            state <= lsu_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid && op_ready) begin
      op_q <= op;
    end
  end

endmodule

`default_nettype wire

//--- rv_mem_arbiter.sv
//############################################################################
// rv memory arbiter
// merges fetch and lsu requests onto the single bus, lsu first, with one
// request outstanding, and steers each response back to its owner
//############################################################################
`timescale 1ns/10ps
`default_nettype none

module rv_mem_arbiter (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   f_req_valid,
  input  rv_bus_pkg::mem_req_t  f_req,
  output logic                  f_req_ready,
  output logic                  f_rsp_valid,
  input  wire                   l_req_valid,
  input  rv_bus_pkg::mem_req_t  l_req,
  output logic                  l_req_ready,
  output logic                  l_rsp_valid,
  output logic                  bus_req_valid,
  output rv_bus_pkg::mem_req_t  bus_req,
  input  wire                   bus_req_ready,
  input  wire                   bus_rsp_valid
);

  rv_bus_pkg::owner_e owner;
  // requester already shown on the bus but not yet accepted
  rv_bus_pkg::owner_e pend;
  logic idle;
  logic grant_lsu;

  assign idle      = owner == rv_bus_pkg::own_none;
  assign grant_lsu = (pend == rv_bus_pkg::own_none) ? l_req_valid
                                                    : (pend == rv_bus_pkg::own_lsu);

  assign bus_req_valid = idle && (grant_lsu ? l_req_valid : f_req_valid);
  assign bus_req       = grant_lsu ? l_req : f_req;
  assign l_req_ready   = idle && grant_lsu && bus_req_ready;
  assign f_req_ready   = idle && !grant_lsu && bus_req_ready;

  assign f_rsp_valid = bus_rsp_valid && owner == rv_bus_pkg::own_fetch;
  assign l_rsp_valid = bus_rsp_valid && owner == rv_bus_pkg::own_lsu;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= rv_bus_pkg::own_none;
      pend  <= rv_bus_pkg::own_none;
    end else begin
      if (bus_req_valid && bus_req_ready) begin
        owner <= grant_lsu ? rv_bus_pkg::own_lsu : rv_bus_pkg::own_fetch;
      end else if (bus_rsp_valid) begin
        owner <= rv_bus_pkg::own_none;
      end
      // keep the grant stable while the bus stalls
      if (bus_req_valid && !bus_req_ready) begin
        pend <= grant_lsu ? rv_bus_pkg::own_lsu : rv_bus_pkg::own_fetch;
      end else begin
        pend <= rv_bus_pkg::own_none;
      end
    end
  end

endmodule

`default_nettype wire

//--- rv_regfile.sv
//############################################################################
// rv register file
// 32 x 32 bit, two combinational read ports, one write port, x0 reads zero
//############################################################################
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module rv_regfile (
  input  wire                  clk,
  input  wire                  rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data,
  input  wire                  we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    rd_data
);

  rv_isa_pkg::word_t regs [`RV_NUM_REGS];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- tb_rv_core.sv
//############################################################################
// rv core testbench
// random rv32i program, bus memory with random ready and latency, and an
// isa model that predicts every store the core puts on the bus
//############################################################################
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module tb_rv_core;

  localparam int NUM_INSNS   = 100;
  localparam int PROG_LEN    = NUM_INSNS + 32;
  localparam int MEM_WORDS   = 512;
  localparam int DATA_BASE   = 'h400;
  localparam int DUMP_BASE   = 'h600;
  localparam int CYCLE_LIMIT = PROG_LEN * (2 * `RV_MAX_LAT + 6) + 200;

  typedef enum logic [2:0] {k_lui, k_imm, k_reg, k_branch, k_load, k_store} gen_kind_e;

  logic clk;
  logic rst;
  logic bus_req_valid;
  logic bus_req_ready;
  logic bus_rsp_valid;
  logic halt;
  rv_bus_pkg::mem_req_t bus_req;
  rv_bus_pkg::mem_rsp_t bus_rsp;

  logic [31:0] rng_state = 32'd12;
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] model_mem [MEM_WORDS];
  logic [31:0] xreg [32];
  gen_kind_e   g_kind [NUM_INSNS];
  logic [2:0]  g_f3 [NUM_INSNS];
  logic        g_alt [NUM_INSNS];
  logic [4:0]  g_rd [NUM_INSNS];
  logic [4:0]  g_rs1 [NUM_INSNS];
  logic [4:0]  g_rs2 [NUM_INSNS];
  logic [31:0] g_imm [NUM_INSNS];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  // bus responder state
  logic        busy = 1'b0;
  logic        first_seen = 1'b0;
  logic        halt_seen = 1'b0;
  logic        stalled = 1'b0;
  int          lat_left = 0;
  int          cycles = 0;
  logic [31:0] rsp_word = '0;
  rv_bus_pkg::mem_req_t stall_req = '0;

  rv_core DUT (
    .clk, .rst, .bus_req_valid, .bus_req, .bus_req_ready,
    .bus_rsp_valid, .bus_rsp, .halt
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rand_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = $signed(a) >>> b[4:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? sa : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected));
    end
  endtask

  // random kept instructions, then the register dump and ecall
  task automatic gen_program();
    logic [31:0] r;
    logic [31:0] u;
    logic [31:0] w;
    logic [11:0] imm12;
    logic [12:0] boff;
    int k;
    for (int i = 0; i < NUM_INSNS; i++) begin
      r = rand_next();
      u = rand_next();
      g_rd[i]  = r[4:0];
      g_rs1[i] = r[9:5];
      g_rs2[i] = r[14:10];
      g_f3[i]  = r[17:15];
      g_alt[i] = 1'b0;
      imm12    = r[31:20];
      g_imm[i] = {{20{imm12[11]}}, imm12};
      case (u[2:0])
        3'd0: begin
          g_kind[i] = k_lui;
          g_imm[i]  = {u[31:12], 12'd0};
          w = {u[31:12], g_rd[i], 7'b0110111};
        end
        3'd1, 3'd2: begin
          g_kind[i] = k_imm;
          if (g_f3[i] == 3'b001 || g_f3[i] == 3'b101) begin
            g_alt[i] = g_f3[i] == 3'b101 && u[3];
            g_imm[i] = {27'd0, imm12[4:0]};
            imm12    = {1'b0, g_alt[i], 5'd0, imm12[4:0]};
          end
          w = {imm12, g_rs1[i], g_f3[i], g_rd[i], 7'b0010011};
        end
        3'd3, 3'd4: begin
          g_kind[i] = k_reg;
          g_alt[i]  = (g_f3[i] == 3'b000 || g_f3[i] == 3'b101) && u[3];
          w = {1'b0, g_alt[i], 5'd0, g_rs2[i], g_rs1[i], g_f3[i], g_rd[i], 7'b0110011};
        end
        3'd5: begin
          g_kind[i] = k_branch;
          // funct3 2 and 3 are not branches, fold them onto bltu and bgeu
          g_f3[i] = (u[5:4] == 2'b01) ? {1'b1, u[4:3]} : u[5:3];
          k = 1 + int'(u[7:6]);
          if (i + k > NUM_INSNS) begin
            k = NUM_INSNS - i;
          end
          boff     = 13'(k * 4);
          g_imm[i] = {19'd0, boff};
          w = {boff[12], boff[10:5], g_rs2[i], g_rs1[i], g_f3[i], boff[4:1], boff[11],
               7'b1100011};
        end
        3'd6: begin
          g_kind[i] = k_load;
          g_rs1[i]  = 5'd0;
          imm12     = 12'(DATA_BASE) | {6'd0, u[9:4]};
          g_imm[i]  = {20'd0, imm12};
          w = {imm12, 5'd0, 3'b010, g_rd[i], 7'b0000011};
        end
        default: begin
          g_kind[i] = k_store;
          g_rs1[i]  = 5'd0;
          imm12     = 12'(DATA_BASE) | {6'd0, u[9:4]};
          g_imm[i]  = {20'd0, imm12};
          w = {imm12[11:5], g_rs2[i], 5'd0, 3'b010, imm12[4:0], 7'b0100011};
        end
      endcase
      mem[i] = w;
    end
    for (int ri = 1; ri < 32; ri++) begin
      imm12 = 12'(DUMP_BASE + 4 * ri);
      mem[NUM_INSNS + ri - 1] = {imm12[11:5], 5'(ri), 5'd0, 3'b010, imm12[4:0], 7'b0100011};
    end
    mem[NUM_INSNS + 31] = 32'h0000_0073;
  endtask

  // isa model, fills the expected store queue
  task automatic run_model();
    int idx;
    int next_idx;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic wr;
    for (int ri = 0; ri < 32; ri++) begin
      xreg[ri] = '0;
    end
    idx = 0;
    while (idx < NUM_INSNS) begin
      a        = xreg[g_rs1[idx]];
      b        = xreg[g_rs2[idx]];
      res      = '0;
      wr       = 1'b1;
      next_idx = idx + 1;
      case (g_kind[idx])
        k_lui:   res = g_imm[idx];
        k_imm:   res = alu_ref(g_f3[idx], g_alt[idx], a, g_imm[idx]);
        k_reg:   res = alu_ref(g_f3[idx], g_alt[idx], a, b);
        k_branch: begin
          wr = 1'b0;
          if (branch_ref(g_f3[idx], a, b)) begin
            next_idx = idx + int'(g_imm[idx] >> 2);
          end
        end
        k_load:  res = model_mem[g_imm[idx][10:2]];
        default: begin
          wr = 1'b0;
          model_mem[g_imm[idx][10:2]] = b;
          exp_addr.push_back(g_imm[idx] & ~32'd3);
          exp_data.push_back(b);
        end
      endcase
      if (wr && g_rd[idx] != 5'd0) begin
        xreg[g_rd[idx]] = res;
      end
      idx = next_idx;
    end
    for (int ri = 1; ri < 32; ri++) begin
      exp_addr.push_back(32'(DUMP_BASE + 4 * ri));
      exp_data.push_back(xreg[ri]);
    end
  endtask

  // one accepted request, reads answered from mem, writes checked and applied
  task automatic serve_request();
    int w;
    w = int'(bus_req.addr[31:2]);
    if (!first_seen) begin
      first_seen = 1'b1;
      check_value("bus_req.addr", bus_req.addr, `RV_RESET_PC);
      check_value("bus_req.write", 32'(bus_req.write), 32'd0);
    end
    if (w >= MEM_WORDS) begin
      fail_run($sformatf("request address 0x%08h is outside the memory", bus_req.addr));
    end
    if (bus_req.write) begin
      if (exp_addr.size() == 0) begin
        fail_run("store seen after the last expected one");
      end else begin
        check_value("bus_req.addr", bus_req.addr, exp_addr.pop_front());
        check_value("bus_req.wdata", bus_req.wdata, exp_data.pop_front());
      end
      mem[w]   = bus_req.wdata;
      rsp_word = '0;
    end else begin
      rsp_word = mem[w];
    end
    lat_left = `RV_MIN_LAT + int'(rand_next() % `RV_MAX_LAT);
    busy     = 1'b1;
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      fail_run($sformatf("timeout, core not halted after %0d cycles", CYCLE_LIMIT));
    end
    if (rst) begin
      bus_req_ready <= 1'b0;
      bus_rsp_valid <= 1'b0;
      busy = 1'b0;
      stalled = 1'b0;
    end else begin
      if (halt_seen && !halt) begin
        fail_run("halt dropped before reset");
      end
      if (halt && bus_req_valid) begin
        fail_run("bus request seen after halt");
      end
      halt_seen = halt_seen || halt;
      // a request left waiting must come back unchanged
      if (stalled) begin
        if (!bus_req_valid) begin
          fail_run("bus request withdrawn while stalled");
        end else begin
          check_value("bus_req.addr", bus_req.addr, stall_req.addr);
          check_value("bus_req.wdata", bus_req.wdata, stall_req.wdata);
          check_value("bus_req.write", 32'(bus_req.write), 32'(stall_req.write));
        end
      end
      stalled   = bus_req_valid && !bus_req_ready;
      stall_req = bus_req;
      bus_rsp_valid <= 1'b0;
      if (busy) begin
        if (lat_left == 1) begin
          bus_rsp_valid <= 1'b1;
          bus_rsp.rdata <= rsp_word;
          busy = 1'b0;
        end else begin
          lat_left = lat_left - 1;
        end
      end
      if (bus_req_valid && bus_req_ready) begin
        serve_request();
      end
      // ready high three cycles in four on average
      bus_req_ready <= (rand_next() & 32'd3) != 32'd0;
    end
  end

  initial begin
    rst           = 1'b1;
    bus_req_ready = 1'b0;
    bus_rsp_valid = 1'b0;
    bus_rsp       = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]       = fill_word(32'(a * 4));
      model_mem[a] = mem[a];
    end
    gen_program();
    run_model();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("halt", 32'(halt), 32'd0);
    while (!halt) begin
      @(posedge clk);
    end
    // give a late response or a stray request time to show
    repeat (2 * `RV_MAX_LAT + 4) @(posedge clk);
    if (exp_addr.size() != 0) begin
      fail_run($sformatf("core halted with %0d expected stores missing", exp_addr.size()));
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
